//--- include/memSys_macros.svh
`ifndef MEMSYS_MACROS_SVH
`define MEMSYS_MACROS_SVH

// byte address into main memory
`define AddrWidth 17

// fetch and data word
`define WordWidth 32

// memory is one byte wide
`define ByteWidth 8

// holds a data length of 1, 2 or 4, and the fetch length 4
`define LenWidth 3

// one byte per address
`define RamDepth (1 << `AddrWidth)

`endif

//--- hw/memPkg.sv
package memPkg;

    // controller sequencing state
    typedef enum logic [1:0] {
        idle      = 2'b00,
        readInst  = 2'b01,
        readData  = 2'b10,
        writeData = 2'b11
    } ctrlState;

    // direction of a data port access
    typedef enum logic {
        load  = 1'b0,
        store = 1'b1
    } accessDir;

    // owner of the byte memory, shown to both requesters
    typedef enum logic [1:0] {
        none      = 2'b00,
        dataOwner = 2'b01,
        instOwner = 2'b10
    } ownerCode;

endpackage

//--- hw/byteRam.sv
`timescale 1ns/1ps
`include "memSys_macros.svh"

module byteRam (
    input  logic                  clk,
    input  logic                  we,
    input  logic [`AddrWidth-1:0] addr,
    input  logic [`ByteWidth-1:0] wdata,
    output logic [`ByteWidth-1:0] rdata
);

    // main memory, one byte per address
    logic [`ByteWidth-1:0] mem [`RamDepth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // one cycle read latency
    // a write and a read of the same address return the old byte
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

//--- hw/memCtrl.sv
`timescale 1ns/1ps
`include "memSys_macros.svh"

module memCtrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  ioFull,

    input  logic                  instEn,
    input  logic [`AddrWidth-1:0] instAddr,
    output logic                  instDone,
    output logic [`WordWidth-1:0] instWord,

    output logic                  bpEn,
    output logic [`WordWidth-1:0] bpInst,

    input  logic                  dataEn,
    input  memPkg::accessDir      dataDir,
    input  logic [`LenWidth-1:0]  dataLen,
    input  logic [`AddrWidth-1:0] dataAddr,
    input  logic [`WordWidth-1:0] dataWrite,
    output logic                  dataDone,
    output logic [`WordWidth-1:0] dataRead,

    output memPkg::ownerCode      instWait,
    output memPkg::ownerCode      dataWait,

    output logic                  memWe,
    output logic [`AddrWidth-1:0] memAddr,
    output logic [`ByteWidth-1:0] memWdata,
    input  logic [`ByteWidth-1:0] memRdata
);
    import memPkg::*;

    ctrlState              state;
    logic [`LenWidth-1:0]  stage;
    logic [`LenWidth-1:0]  len;
    logic [`AddrWidth-1:0] baseAddr;
    logic [`AddrWidth-1:0] lastAddr;
    logic [`AddrWidth-1:0] issueAddr;
    logic [`WordWidth-1:0] asmWord;
    logic [`WordWidth-1:0] storeWord;
    logic [`WordWidth-1:0] readWord;
    logic [1:0]            byteIdx;
    logic                  run;
    logic                  readLast;
    logic                  writeLast;
    ownerCode              owner;

    // whole subsystem stands still on either condition
    assign run = rdy && !ioFull;

    assign issueAddr = baseAddr + {{(`AddrWidth-`LenWidth){1'b0}}, stage};

    // byte returned by the RAM in this stage (stage 4 wraps to lane 3)
    assign byteIdx = stage[1:0] - 2'd1;

    assign readLast  = (stage == len);
    assign writeLast = (stage == len - 3'd1);

    // last byte comes straight from the RAM, upper lanes stay zero
    assign readWord = asmWord |
        ({{(`WordWidth-`ByteWidth){1'b0}}, memRdata} << (byteIdx * `ByteWidth));

    assign instWord = readWord;
    assign bpInst   = readWord;
    assign dataRead = readWord;

    assign instDone = run && (state == readInst) && readLast;
    assign bpEn     = instDone;
    assign dataDone = run && (((state == readData) && readLast) ||
                              ((state == writeData) && writeLast));

    // while frozen the RAM re-reads its last address so memRdata holds
    assign memAddr  = run ? issueAddr : lastAddr;
    assign memWe    = run && (state == writeData);
    assign memWdata = storeWord[`ByteWidth-1:0];

    always_comb begin
        case (state)
            readInst:  owner = instOwner;
            readData:  owner = dataOwner;
            writeData: owner = dataOwner;
            default:   owner = none;
        endcase
    end

    assign instWait = owner;
    assign dataWait = owner;

    // state and stage counter
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            stage <= '0;
        end else if (run) begin
            case (state)
                idle: begin
                    stage <= '0;
                    // data wins over fetch
                    if (dataEn) begin
                        state <= (dataDir == store) ? writeData : readData;
                    end else if (instEn) begin
                        state <= readInst;
                    end
                end
                readInst, readData: begin
                    if (readLast) begin
                        state <= idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                writeData: begin
                    if (writeLast) begin
                        state <= idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    state <= idle;
                    stage <= '0;
                end
            endcase
        end
    end

    // request copy, byte assembly and store shifter
    always_ff @(posedge clk) begin
        if (run) begin
            lastAddr <= issueAddr;
            case (state)
                idle: begin
                    asmWord <= '0;
                    if (dataEn) begin
                        baseAddr  <= dataAddr;
                        len       <= dataLen;
                        storeWord <= dataWrite;
                    end else if (instEn) begin
                        baseAddr <= instAddr;
                        len      <= 3'd4;
                    end
                end
                readInst, readData: begin
                    // stage 0 only issues the first address
                    if (stage != '0 && !readLast) begin
                        asmWord[byteIdx*`ByteWidth +: `ByteWidth] <= memRdata;
                    end
                end
                writeData: begin
                    storeWord <= storeWord >> `ByteWidth;
                end
                default: begin
                    asmWord <= '0;
                end
            endcase
        end
    end

endmodule

//--- hw/memSys.sv
`timescale 1ns/1ps
`include "memSys_macros.svh"

module memSys (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  ioFull,

    input  logic                  instEn,
    input  logic [`AddrWidth-1:0] instAddr,
    output logic                  instDone,
    output logic [`WordWidth-1:0] instWord,

    output logic                  bpEn,
    output logic [`WordWidth-1:0] bpInst,

    input  logic                  dataEn,
    input  memPkg::accessDir      dataDir,
    input  logic [`LenWidth-1:0]  dataLen,
    input  logic [`AddrWidth-1:0] dataAddr,
    input  logic [`WordWidth-1:0] dataWrite,
    output logic                  dataDone,
    output logic [`WordWidth-1:0] dataRead,

    output memPkg::ownerCode      instWait,
    output memPkg::ownerCode      dataWait
);

    // byte RAM port, write enable already qualified by rdy and ioFull
    logic                  memWe;
    logic [`AddrWidth-1:0] memAddr;
    logic [`ByteWidth-1:0] memWdata;
    logic [`ByteWidth-1:0] memRdata;

    memCtrl ctrl (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .instEn    (instEn),
        .instAddr  (instAddr),
        .instDone  (instDone),
        .instWord  (instWord),
        .bpEn      (bpEn),
        .bpInst    (bpInst),
        .dataEn    (dataEn),
        .dataDir   (dataDir),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataDone  (dataDone),
        .dataRead  (dataRead),
        .instWait  (instWait),
        .dataWait  (dataWait),
        .memWe     (memWe),
        .memAddr   (memAddr),
        .memWdata  (memWdata),
        .memRdata  (memRdata)
    );

    byteRam ram (
        .clk   (clk),
        .we    (memWe),
        .addr  (memAddr),
        .wdata (memWdata),
        .rdata (memRdata)
    );

endmodule

//--- verif/memSysTb.sv
`timescale 1ns/1ps
`include "memSys_macros.svh"

module memSysTb;
    import memPkg::*;

    localparam int kindFetch = 0;
    localparam int kindLoad  = 1;
    localparam int kindStore = 2;
    localparam int kindDual  = 3;

    logic                  clk;
    logic                  rst;
    logic                  rdy;
    logic                  ioFull;
    logic                  instEn;
    logic [`AddrWidth-1:0] instAddr;
    logic                  instDone;
    logic [`WordWidth-1:0] instWord;
    logic                  bpEn;
    logic [`WordWidth-1:0] bpInst;
    logic                  dataEn;
    accessDir              dataDir;
    logic [`LenWidth-1:0]  dataLen;
    logic [`AddrWidth-1:0] dataAddr;
    logic [`WordWidth-1:0] dataWrite;
    logic                  dataDone;
    logic [`WordWidth-1:0] dataRead;
    ownerCode              instWait;
    ownerCode              dataWait;

    // operations from the golden file
    int                    kindList[$];
    logic [`AddrWidth-1:0] addrList[$];
    int                    lenList[$];
    logic [`WordWidth-1:0] writeList[$];
    logic [`WordWidth-1:0] wantList[$];
    bit                    stallList[$];

    int errorCount;
    int passCount;
    int failCount;
    int opTotal;
    bit stallOn;

    memSys uut (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .instEn    (instEn),
        .instAddr  (instAddr),
        .instDone  (instDone),
        .instWord  (instWord),
        .bpEn      (bpEn),
        .bpInst    (bpInst),
        .dataEn    (dataEn),
        .dataDir   (dataDir),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataDone  (dataDone),
        .dataRead  (dataRead),
        .instWait  (instWait),
        .dataWait  (dataWait)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic checkValue(input logic [31:0] seen, input logic [31:0] want,
                              input string what);
        if (seen !== want) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, seen, want);
            errorCount++;
        end
    endtask

    function automatic string kindName(input int kind);
        case (kind)
            kindFetch: return "fetch";
            kindLoad:  return "load";
            kindStore: return "store";
            default:   return "dual";
        endcase
    endfunction

    task automatic readGolden();
        int fd;
        int got;
        int lineNo;
        string line;
        logic [63:0] kindText;
        logic [31:0] addrVal;
        logic [31:0] wdataVal;
        logic [31:0] wantVal;
        int lenVal;
        int stallVal;
        lineNo = 0;
        fd = $fopen("verif/memSysGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file verif/memSysGolden.txt");
            errorCount++;
        end else begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                lineNo++;
                // skip comments and empty lines
                if (got > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%s %h %d %h %h %d", kindText, addrVal, lenVal,
                                  wdataVal, wantVal, stallVal);
                    if (got != 6) begin
                        $display("golden line %0d could not be parsed", lineNo);
                        errorCount++;
                    end else if (kindText == 64'("fetch") || kindText == 64'("load") ||
                                 kindText == 64'("store") || kindText == 64'("dual")) begin
                        if (kindText == 64'("fetch")) kindList.push_back(kindFetch);
                        else if (kindText == 64'("load")) kindList.push_back(kindLoad);
                        else if (kindText == 64'("store")) kindList.push_back(kindStore);
                        else kindList.push_back(kindDual);
                        addrList.push_back(addrVal[`AddrWidth-1:0]);
                        lenList.push_back(lenVal);
                        writeList.push_back(wdataVal);
                        wantList.push_back(wantVal);
                        stallList.push_back(stallVal != 0);
                    end else begin
                        $display("golden line %0d has an unknown operation kind", lineNo);
                        errorCount++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // counts clock cycles from the request until done is seen at a falling edge
    task automatic waitDone(input bit fetchSide, output int cycles);
        cycles = 0;
        @(negedge clk);
        while ((fetchSide ? instDone : dataDone) !== 1'b1) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic checkOwner(input ownerCode want, input string what);
        checkValue(32'(instWait), 32'(want), {what, " seen by fetch port"});
        checkValue(32'(dataWait), 32'(want), {what, " seen by data port"});
    endtask

    task automatic checkFetchResult(input logic [31:0] want);
        checkValue(instWord, want, "fetched word");
        checkValue(bpInst, want, "predictor word");
        checkValue({31'd0, bpEn}, 32'd1, "bpEn together with instDone");
        checkOwner(instOwner, "owner during fetch");
    endtask

    task automatic loadBytes(input logic [`AddrWidth-1:0] addr, input int len,
                             input logic [31:0] want, input bit stalled);
        int cycles;
        @(posedge clk);
        #2;
        dataEn   = 1'b1;
        dataDir  = load;
        dataLen  = len[2:0];
        dataAddr = addr;
        waitDone(1'b0, cycles);
        checkValue(dataRead, want, "load data");
        checkOwner(dataOwner, "owner during load");
        if (!stalled) begin
            checkValue(32'(cycles), 32'(len + 1), "load latency");
        end
        @(posedge clk);
        #2;
        dataEn = 1'b0;
    endtask

    task automatic storeBytes(input logic [`AddrWidth-1:0] addr, input int len,
                              input logic [31:0] wdata, input bit stalled);
        int cycles;
        @(posedge clk);
        #2;
        dataEn    = 1'b1;
        dataDir   = store;
        dataLen   = len[2:0];
        dataAddr  = addr;
        dataWrite = wdata;
        waitDone(1'b0, cycles);
        checkOwner(dataOwner, "owner during store");
        if (!stalled) begin
            checkValue(32'(cycles), 32'(len), "store latency");
        end
        @(posedge clk);
        #2;
        dataEn = 1'b0;
    endtask

    task automatic fetchWord(input logic [`AddrWidth-1:0] addr, input logic [31:0] want,
                             input bit stalled);
        int cycles;
        @(posedge clk);
        #2;
        instEn   = 1'b1;
        instAddr = addr;
        waitDone(1'b1, cycles);
        checkFetchResult(want);
        if (!stalled) begin
            checkValue(32'(cycles), 32'd5, "fetch latency");
        end
        @(posedge clk);
        #2;
        instEn = 1'b0;
    endtask

    // both ports at once so the store has to land before the fetch reads
    task automatic storeThenFetch(input logic [`AddrWidth-1:0] addr, input int len,
                                  input logic [31:0] wdata, input logic [31:0] want);
        int cycles;
        @(posedge clk);
        #2;
        dataEn    = 1'b1;
        dataDir   = store;
        dataLen   = len[2:0];
        dataAddr  = addr;
        dataWrite = wdata;
        instEn    = 1'b1;
        instAddr  = addr;
        @(negedge clk);
        while (dataDone !== 1'b1) begin
            checkValue({31'd0, instDone}, 32'd0, "fetch finished before the data store");
            @(negedge clk);
        end
        checkOwner(dataOwner, "owner during store");
        @(posedge clk);
        #2;
        dataEn = 1'b0;
        @(negedge clk);
        checkOwner(none, "owner between accesses");
        waitDone(1'b1, cycles);
        checkFetchResult(want);
        @(posedge clk);
        #2;
        instEn = 1'b0;
    endtask

    task automatic checkReset();
        @(negedge clk);
        checkValue({31'd0, instDone}, 32'd0, "instDone after reset");
        checkValue({31'd0, dataDone}, 32'd0, "dataDone after reset");
        checkValue({31'd0, bpEn}, 32'd0, "bpEn after reset");
        checkOwner(none, "owner after reset");
    endtask

    // new rdy and ioFull values each cycle while stalls are on
    initial begin
        rdy    = 1'b1;
        ioFull = 1'b0;
        void'($urandom(32'ha5cd));
        forever begin
            @(posedge clk);
            #2;
            if (stallOn) begin
                rdy    = ($urandom % 4) != 0;
                ioFull = ($urandom % 6) == 0;
            end else begin
                rdy    = 1'b1;
                ioFull = 1'b0;
            end
        end
    end

    initial begin
        wait (opTotal > 0);
        #((opTotal * 40 + 16) * 20);
        $display("run timed out after %0d cycles", opTotal * 40 + 16);
        $display("Something failed");
        $finish;
    end

    initial begin
        int errorsBefore;
        rst        = 1'b1;
        instEn     = 1'b0;
        instAddr   = '0;
        dataEn     = 1'b0;
        dataDir    = load;
        dataLen    = '0;
        dataAddr   = '0;
        dataWrite  = '0;
        stallOn    = 1'b0;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;
        opTotal    = 0;
        readGolden();
        if (kindList.size() == 0) begin
            $display("golden file holds no operations");
            errorCount++;
        end
        opTotal = kindList.size();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        errorsBefore = errorCount;
        checkReset();
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test 0 reset: passed");
        end else begin
            failCount++;
            $display("test 0 reset: failed");
        end

        for (int i = 0; i < opTotal; i++) begin
            errorsBefore = errorCount;
            stallOn = stallList[i];
            case (kindList[i])
                kindFetch: fetchWord(addrList[i], wantList[i], stallList[i]);
                kindLoad:  loadBytes(addrList[i], lenList[i], wantList[i], stallList[i]);
                kindStore: storeBytes(addrList[i], lenList[i], writeList[i], stallList[i]);
                default:   storeThenFetch(addrList[i], lenList[i], writeList[i], wantList[i]);
            endcase
            stallOn = 1'b0;
            if (errorCount == errorsBefore) begin
                passCount++;
                $display("test %0d %s at %h len %0d: passed", i + 1, kindName(kindList[i]),
                         addrList[i], lenList[i]);
            end else begin
                failCount++;
                $display("test %0d %s at %h len %0d: failed", i + 1, kindName(kindList[i]),
                         addrList[i], lenList[i]);
            end
        end

        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- memSys.f
+incdir+include
hw/memPkg.sv
hw/byteRam.sv
hw/memCtrl.sv
hw/memSys.sv
verif/memSysTb.sv

//--- run.sh
#!/bin/sh
# builds the memory subsystem testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --timescale 1ns/1ps \
    --top-module memSysTb -f memSys.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VmemSysTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not report a pass, see $LOG"
    exit 1
fi

//--- verif/memSysGolden.txt
# kind addr len wdata expected stall (addr, wdata and expected in hex)
# dual stores at addr and fetches from addr, expected is the fetched word
store 00100 4 11223344 00000000 0
store 00104 4 55667788 00000000 0
store 00108 4 99aabbcc 00000000 0
store 0010c 4 ddeeff00 00000000 0
store 1fffc 4 cafef00d 00000000 0
store 00200 4 01234567 00000000 0
store 00204 4 89abcdef 00000000 0
store 00304 4 0f0e0d0c 00000000 0
load 00100 4 00000000 11223344 0
load 00104 4 00000000 55667788 0
load 1fffc 4 00000000 cafef00d 0
load 00102 4 00000000 77881122 0
load 0010a 4 00000000 ff0099aa 0
load 00100 1 00000000 00000044 0
load 00101 1 00000000 00000033 0
load 00107 1 00000000 00000055 0
load 0010c 1 00000000 00000000 0
load 00100 2 00000000 00003344 0
load 00103 2 00000000 00008811 0
load 0010d 2 00000000 0000eeff 0
load 1fffe 2 00000000 0000cafe 0
store 00100 1 000000aa 00000000 0
load 00100 4 00000000 112233aa 0
store 00105 2 0000beef 00000000 0
load 00104 4 00000000 55beef88 0
store 00109 1 ffffff5a 00000000 0
load 00108 4 00000000 99aa5acc 0
store 0010e 2 ffff1357 00000000 0
load 0010c 4 00000000 1357ff00 0
load 0010e 2 00000000 00001357 0
store 00201 2 0000c0de 00000000 0
load 00200 4 00000000 01c0de67 0
load 00201 1 00000000 000000de 0
fetch 00104 4 00000000 55beef88 0
fetch 00200 4 00000000 01c0de67 0
fetch 00204 4 00000000 89abcdef 0
fetch 00102 4 00000000 ef881122 0
fetch 1fffc 4 00000000 cafef00d 0
dual 00300 4 a1b2c3d4 a1b2c3d4 0
dual 00300 1 000000ee a1b2c3ee 0
dual 00302 2 00007788 0d0c7788 0
dual 00108 2 00004321 99aa4321 0
store 00400 4 deadbeef 00000000 1
load 00400 4 00000000 deadbeef 1
store 00402 1 00000077 00000000 1
load 00400 4 00000000 de77beef 1
load 00401 2 00000000 000077be 1
fetch 00400 4 00000000 de77beef 1
store 00404 4 76543210 00000000 1
fetch 00402 4 00000000 3210de77 1
load 00403 1 00000000 000000de 1
dual 00404 2 0000abcd 7654abcd 1
load 00404 4 00000000 7654abcd 1
load 00100 2 00000000 000033aa 1
fetch 0010c 4 00000000 1357ff00 1
dual 00300 4 5a5aa5a5 5a5aa5a5 1
load 00302 2 00000000 00005a5a 1
load 00200 2 00000000 0000de67 0
load 00302 4 00000000 0d0c5a5a 0
fetch 00300 4 00000000 5a5aa5a5 0
